// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_vic_top
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
FILELIST  ?= src.f
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@! grep -q "STATUS: FAIL" $(LOG)
	@grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/tb_vic_top.sv
`default_nettype none

module tb_vic_top;

   localparam int reset_cycles = 16;
   localparam int reg_ops      = 1500;         // accesses in the readback test
   localparam int raster_reads = 2000;         // about one frame of beam reads
   localparam int frame_clocks = vic_pkg::line_pixels * vic_pkg::frame_lines;
   // worst case length of each test plus slack
   localparam int cycle_limit  = reset_cycles + reg_ops * 8 + raster_reads * 80 +
                                 2 * (frame_clocks + 64) + 1000;
   localparam logic [5:0] rw_regs [0:2] = '{vic_pkg::reg_border, vic_pkg::reg_background,
                                           vic_pkg::reg_irq_enable};

   logic       clk_col16x_ntsc;
   logic       reset;
   logic       ce;                             // low active
   logic       rw;                             // high reads
   logic [5:0] adi;
   logic [7:0] dbi;
   wire  [7:0] dbo;
   wire        vic_write_db;
   wire        irq;
   wire        hsync;
   wire        vsync;
   wire  [5:0] luma;
   wire  [5:0] chroma;
   int         checks;                         // from the checker
   int         errors;
   int         tb_errors = 0;                  // failures seen by the stimulus
   int         reported  = 0;                  // error total at the last test end
   int         cycles    = 0;
   integer     seed      = 32'he965_c785;
   logic [7:0] rdata;                          // last byte read
   logic [8:0] cmp_line;                       // raster irq line

   vic_top vic_top_i (.*);
   vic_checker checker_i (.*);

   initial
   begin
      clk_col16x_ntsc = 1'b0;
      forever #5 clk_col16x_ntsc = ~clk_col16x_ntsc;
   end

   always @(posedge clk_col16x_ntsc)
   begin
      cycles <= cycles + 1;
      if (cycles == cycle_limit)
      begin
         $display("timeout after %0d cycles, the run did not finish", cycles);
         $display("STATUS: FAIL");
         $finish;
      end
   end

   function automatic int pick(input int range);
      return int'($unsigned($random(seed)) % range);
   endfunction

   // one clock access, called just after a rising edge
   task automatic bus_write(input logic [5:0] addr, input logic [7:0] data);
      ce  <= 1'b0;
      rw  <= 1'b0;
      adi <= addr;
      dbi <= data;
      @(posedge clk_col16x_ntsc);
      ce  <= 1'b1;
      rw  <= 1'b1;
   endtask

   task automatic bus_read(input logic [5:0] addr, output logic [7:0] data);
      ce  <= 1'b0;
      rw  <= 1'b1;
      adi <= addr;
      @(posedge clk_col16x_ntsc);
      ce  <= 1'b1;
      @(posedge clk_col16x_ntsc);              // dbo valid this clock only
      data = dbo;
   endtask

   task automatic idle(input int n);
      repeat (n) @(posedge clk_col16x_ntsc);
   endtask

   task automatic test_done(input string name);
      $display("test %s finished with %0d errors", name, errors + tb_errors - reported);
      reported = errors + tb_errors;
   endtask

   initial
   begin
      reset = 1'b1;
      ce    = 1'b1;
      rw    = 1'b1;
      adi   = 6'h00;
      dbi   = 8'h00;
      repeat (reset_cycles) @(posedge clk_col16x_ntsc);
      reset <= 1'b0;

      repeat (reg_ops)
      begin
         case (pick(3))
            0:       bus_write(rw_regs[pick(3)], 8'(pick(256)));
            1:       bus_read(rw_regs[pick(3)], rdata);
            default: bus_read(pick(2) ? 6'(pick(17)) : 6'(34 + pick(30)), rdata);   // unmapped
         endcase
         idle(pick(4));                        // zero gives back to back accesses
      end
      test_done("register readback");

      repeat (raster_reads)
      begin
         idle(50 + pick(28));
         case (pick(6))
            0:       bus_write(vic_pkg::reg_ctrl1, 8'(pick(256)));     // den and compare bit 8
            1:       bus_write(rw_regs[pick(2)], 8'(pick(256)));       // a colour
            2, 3:    bus_read(vic_pkg::reg_raster, rdata);
            default: bus_read(vic_pkg::reg_ctrl1, rdata);
         endcase
      end
      test_done("raster readback and video");

      cmp_line = 9'(pick(vic_pkg::frame_lines));
      bus_write(vic_pkg::reg_irq_enable, 8'h00);
      bus_write(vic_pkg::reg_raster, cmp_line[7:0]);
      bus_write(vic_pkg::reg_ctrl1, {cmp_line[8], 7'h10});   // display on
      bus_write(vic_pkg::reg_irq_status, 8'h01);             // drop a stale pending bit
      bus_write(vic_pkg::reg_irq_enable, 8'h01);
      for (int i = 0; i < frame_clocks + 8 && irq !== 1'b0; i++)
         @(posedge clk_col16x_ntsc);
      if (irq !== 1'b0)
      begin
         $display("irq never went low within one frame for line %0d", cmp_line);
         tb_errors = tb_errors + 1;
      end
      bus_read(vic_pkg::reg_irq_status, rdata);
      bus_write(vic_pkg::reg_irq_status, 8'h01);             // acknowledge
      idle(4);
      test_done("raster irq enabled");

      bus_write(vic_pkg::reg_irq_enable, 8'h00);
      cmp_line = 9'(pick(vic_pkg::frame_lines));
      bus_write(vic_pkg::reg_raster, cmp_line[7:0]);
      bus_write(vic_pkg::reg_ctrl1, {cmp_line[8], 7'h10});
      rdata = 8'h00;
      for (int i = 0; i < (frame_clocks + 64) / 32 && !rdata[0]; i++)
      begin
         bus_read(vic_pkg::reg_irq_status, rdata);
         idle(30);
      end
      if (!rdata[0])
      begin
         $display("status bit 0 never set with the raster irq masked");
         tb_errors = tb_errors + 1;
      end
      test_done("raster irq masked");

      idle(2);
      $display("%0d checks, %0d errors", checks, errors + tb_errors);
      if (errors + tb_errors == 0)
         $display("STATUS: PASS");
      else
         $display("STATUS: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

// File: bench/vic_checker.sv
`default_nettype none

module vic_checker (
   input  wire        clk_col16x_ntsc,
   input  wire        reset,
   input  wire        ce,
   input  wire        rw,
   input  wire [5:0]  adi,
   input  wire [7:0]  dbi,
   input  wire [7:0]  dbo,
   input  wire        vic_write_db,
   input  wire        irq,
   input  wire        hsync,
   input  wire        vsync,
   input  wire [5:0]  luma,
   input  wire [5:0]  chroma,
   output int         checks,                 // compares made
   output int         errors                  // compares that failed
);

   int unsigned m_pix;                        // model beam pixel of the clock now ending
   int unsigned m_line;                       // model beam line
   logic [7:0]  m_ctrl1;                      // control 1 raw byte with den at bit 4
   logic [7:0]  m_rlo;                        // compare line low byte
   logic [3:0]  m_en;                         // irq enable
   logic [3:0]  m_border;
   logic [3:0]  m_bg;
   logic        m_pend;                       // raster irq pending
   logic [3:0]  m_color;                      // colour at the beam
   logic        armed  = 1'b0;                // outputs defined after a reset edge
   logic        pix_ok = 1'b0;                // luma and chroma defined
   logic [3:0]  exp_flags;                    // hsync, vsync, irq, vic_write_db
   logic [7:0]  exp_dbo;
   logic [5:0]  exp_luma;
   logic [5:0]  exp_chroma;

   initial
   begin
      checks = 0;
      errors = 0;
   end

   // byte returned for a read by the register map rules
   function automatic logic [7:0] read_value(input logic [5:0] addr);
      case (addr)
         vic_pkg::reg_ctrl1:      return {m_line[8], m_ctrl1[6:0]};   // beam bit 8 on top
         vic_pkg::reg_raster:     return m_line[7:0];
         vic_pkg::reg_irq_status: return {m_pend & m_en[0], 6'd0, m_pend};
         vic_pkg::reg_irq_enable: return {4'hF, m_en};
         vic_pkg::reg_border:     return {4'hF, m_border};
         vic_pkg::reg_background: return {4'hF, m_bg};
         default:                 return 8'hFF;
      endcase
   endfunction

   task automatic compare(input string name, input logic [7:0] exp, input logic [7:0] got);
      checks = checks + 1;
      if (got !== exp)
      begin
         errors = errors + 1;
         $display("ERR %s expected %h got %h at %0t", name, exp, got, $time);
      end
   endtask

   // outputs seen at this edge were set up at the previous one
   always @(posedge clk_col16x_ntsc)
   begin
      if (armed)
      begin
         compare("hsync", 8'(exp_flags[3]), 8'(hsync));
         compare("vsync", 8'(exp_flags[2]), 8'(vsync));
         compare("irq", 8'(exp_flags[1]), 8'(irq));
         compare("vic_write_db", 8'(exp_flags[0]), 8'(vic_write_db));
         if (exp_flags[0])
            compare("dbo", exp_dbo, dbo);         // read data only while driven
         if (pix_ok)
         begin
            compare("luma", 8'(exp_luma), 8'(luma));
            compare("chroma", 8'(exp_chroma), 8'(chroma));
         end
      end
      if (reset)
      begin
         armed     = 1'b1;
         pix_ok    = 1'b0;
         exp_flags = 4'b0010;                  // irq released and the rest low
         m_pix     = 0;
         m_line    = 0;
         {m_ctrl1, m_rlo, m_en, m_border, m_bg, m_pend} = '0;
      end
      else
      begin
         m_color = (m_ctrl1[4] && m_pix >= vic_pkg::win_x_start &&
                    m_pix < vic_pkg::win_x_end && m_line >= vic_pkg::win_y_start &&
                    m_line < vic_pkg::win_y_end) ? m_bg : m_border;
         exp_luma   = vic_pkg::luma_palette[m_color];
         exp_chroma = vic_pkg::chroma_palette[m_color];
         pix_ok     = 1'b1;
         exp_flags  = {m_pix >= vic_pkg::hsync_start && m_pix < vic_pkg::hsync_end,
                       m_line >= vic_pkg::vsync_start && m_line < vic_pkg::vsync_end,
                       ~(m_pend & m_en[0]), ~ce & rw};
         exp_dbo    = read_value(adi);
         if (m_pix == 0 && m_line == {m_ctrl1[7], m_rlo})
            m_pend = 1'b1;                     // a hit beats an ack in the same clock
         else if (!ce && !rw && adi == vic_pkg::reg_irq_status && dbi[0])
            m_pend = 1'b0;
         if (!ce && !rw)                       // new settings apply from the next clock
            case (adi)
               vic_pkg::reg_ctrl1:      m_ctrl1  = dbi;
               vic_pkg::reg_raster:     m_rlo    = dbi;
               vic_pkg::reg_irq_enable: m_en     = dbi[3:0];
               vic_pkg::reg_border:     m_border = dbi[3:0];
               vic_pkg::reg_background: m_bg     = dbi[3:0];
               default:                 ;
            endcase
         m_pix = (m_pix + 1) % vic_pkg::line_pixels;
         if (m_pix == 0)
            m_line = (m_line + 1) % vic_pkg::frame_lines;
      end
   end

endmodule

`default_nettype wire

// File: src.f
verilog/vic_pkg.sv
verilog/vic_cfg_if.sv
verilog/vic_registers.sv
verilog/vic_raster.sv
verilog/vic_pixel.sv
verilog/vic_top.sv
bench/vic_checker.sv
bench/tb_vic_top.sv

// File: verilog/vic_cfg_if.sv
`default_nettype none

interface vic_cfg_if;

   vic_pkg::color_t border;       // border colour index
   vic_pkg::color_t background;   // background colour index
   logic            den;          // display window enabled
   vic_pkg::line_t  raster_cmp;   // irq compare line, 9 bits
   vic_pkg::line_t  raster_line;  // line being drawn now
   logic            raster_hit;   // pixel 0 of the compare line

   // register side sets the look, reads back the beam
   modport regs (
      output border,
      output background,
      output den,
      output raster_cmp,
      input  raster_line,
      input  raster_hit
   );

   // video side follows the settings and reports the beam
   modport video (
      input  border,
      input  background,
      input  den,
      input  raster_cmp,
      output raster_line,
      output raster_hit
   );

endinterface

`default_nettype wire

// File: verilog/vic_pixel.sv
`default_nettype none

module vic_pixel (
   input  wire             clk_col16x_ntsc,
   input  wire             reset,
   input  vic_pkg::pix_t   pix_x,          // beam pixel
   input  vic_pkg::line_t  line,           // beam line
   vic_cfg_if.video        cfg,
   output logic            hsync,
   output logic            vsync,
   output logic [5:0]      luma,
   output logic [5:0]      chroma
);

   logic            hsync_c;               // inside hsync span
   logic            vsync_c;               // inside vsync span
   logic            in_win;                // inside the display window
   vic_pkg::color_t pix_color;             // chosen colour index

   // span decode on the current position
   assign hsync_c = (pix_x >= vic_pkg::hsync_start) && (pix_x < vic_pkg::hsync_end);
   assign vsync_c = (line >= vic_pkg::vsync_start) && (line < vic_pkg::vsync_end);
   assign in_win  = (pix_x >= vic_pkg::win_x_start) && (pix_x < vic_pkg::win_x_end) &&
                    (line  >= vic_pkg::win_y_start) && (line  < vic_pkg::win_y_end);

   // background only shows inside the window with display on
   assign pix_color = (in_win && cfg.den) ? cfg.background : cfg.border;

   // sync outputs, one clock behind the beam
   always_ff @(posedge clk_col16x_ntsc)
   begin
      if (reset)
      begin
         hsync <= 1'b0;
         vsync <= 1'b0;
      end
      else
      begin
         hsync <= hsync_c;
         vsync <= vsync_c;
      end
   end

   // palette lookup, same latency as sync
   always_ff @(posedge clk_col16x_ntsc)
   begin
      luma   <= vic_pkg::luma_palette[pix_color];
      chroma <= vic_pkg::chroma_palette[pix_color];
   end

endmodule

`default_nettype wire

// File: verilog/vic_pkg.sv
`default_nettype none

package vic_pkg;

   // raster geometry, ntsc 65 cycle lines
   localparam int unsigned line_pixels = 520;         // 65 cycles of 8 pixels
   localparam int unsigned frame_lines = 263;         // lines per ntsc frame

   // sync spans, start inclusive, end exclusive
   localparam int unsigned hsync_start = 400;
   localparam int unsigned hsync_end   = 440;
   localparam int unsigned vsync_start = 14;
   localparam int unsigned vsync_end   = 17;

   // visible display window inside the border
   localparam int unsigned win_x_start = 24;
   localparam int unsigned win_x_end   = 344;
   localparam int unsigned win_y_start = 51;
   localparam int unsigned win_y_end   = 251;

   // cpu register map
   localparam logic [5:0] reg_ctrl1      = 6'h11;   // control 1, raster bit 8 on top
   localparam logic [5:0] reg_raster     = 6'h12;   // raster line low byte
   localparam logic [5:0] reg_irq_status = 6'h19;   // pending bits, write 1 to ack
   localparam logic [5:0] reg_irq_enable = 6'h1A;   // irq mask
   localparam logic [5:0] reg_border     = 6'h20;   // border colour
   localparam logic [5:0] reg_background = 6'h21;   // background colour 0

   typedef logic [3:0] color_t;                      // palette index
   typedef logic [8:0] line_t;                       // raster line number
   typedef logic [9:0] pix_t;                        // pixel within line

   // luma level per colour, index 0 listed first
   localparam logic [0:15][5:0] luma_palette = {
      6'h0c, 6'h3f, 6'h1c, 6'h2e, 6'h21, 6'h27, 6'h17, 6'h35,
      6'h21, 6'h17, 6'h27, 6'h1c, 6'h26, 6'h35, 6'h26, 6'h2e
   };

   // chroma phase code, greys carry none
   localparam logic [0:15][5:0] chroma_palette = {
      6'h00, 6'h00, 6'h0a, 6'h2a, 6'h12, 6'h32, 6'h22, 6'h02,
      6'h06, 6'h3e, 6'h0a, 6'h00, 6'h00, 6'h32, 6'h22, 6'h00
   };

   // control register 1, seen as fields or as the raw bus byte
   typedef union packed {
      struct packed {
         logic       rst8;     // raster compare bit 8
         logic       ecm;      // extended colour mode
         logic       bmm;      // bitmap mode
         logic       den;      // display enable
         logic       rsel;     // 25/24 row select
         logic [2:0] yscroll;  // vertical fine scroll
      } f;
      logic [7:0] raw;
   } vic_ctrl1_u;

endpackage

`default_nettype wire

// File: verilog/vic_raster.sv
`default_nettype none

module vic_raster (
   input  wire             clk_col16x_ntsc,
   input  wire             reset,
   vic_cfg_if.video        cfg,
   output vic_pkg::pix_t   pix_x,          // current pixel in line
   output vic_pkg::line_t  line            // current raster line
);

   localparam vic_pkg::pix_t  last_pix  = vic_pkg::pix_t'(vic_pkg::line_pixels - 1);
   localparam vic_pkg::line_t last_line = vic_pkg::line_t'(vic_pkg::frame_lines - 1);

   vic_pkg::pix_t  pix_q;                  // pixel counter
   vic_pkg::line_t line_q;                 // line counter
   logic           line_end;               // last pixel of the line
   logic           frame_end;              // last line of the frame

   assign line_end  = (pix_q == last_pix);
   assign frame_end = (line_q == last_line);

   // pixel counter, one step per clock
   always_ff @(posedge clk_col16x_ntsc)
   begin
      if (reset)
      begin
         pix_q <= '0;                          // first clock out of reset is pixel 0
      end
      else if (line_end)
      begin
         pix_q <= '0;
      end
      else
      begin
         pix_q <= pix_q + vic_pkg::pix_t'(1);
      end
   end

   // line counter, steps on the pixel wrap
   always_ff @(posedge clk_col16x_ntsc)
   begin
      if (reset)
      begin
         line_q <= '0;
      end
      else if (line_end)
      begin
         if (frame_end)
         begin
            line_q <= '0;                      // back to top of frame
         end
         else
         begin
            line_q <= line_q + vic_pkg::line_t'(1);
         end
      end
   end

   // status back to the register block
   assign cfg.raster_line = line_q;
   assign cfg.raster_hit  = (pix_q == '0) && (line_q == cfg.raster_cmp);   // one clock wide

   // beam position for the pixel stage
   assign pix_x = pix_q;
   assign line  = line_q;

endmodule

`default_nettype wire

// File: verilog/vic_registers.sv
`default_nettype none

module vic_registers (
   input  wire             clk_col16x_ntsc,
   input  wire             reset,
   input  wire             ce,             // chip enable, low active
   input  wire             rw,             // high reads
   input  wire [5:0]       adi,            // register address
   input  wire [7:0]       dbi,            // cpu write data
   output logic [7:0]      dbo,            // cpu read data
   output logic            vic_write_db,   // we own the data bus this clock
   output logic            irq,            // low active
   vic_cfg_if.regs         cfg
);

   vic_pkg::vic_ctrl1_u ctrl1;             // control register 1
   logic [7:0]          raster_lo;         // compare line bits 7..0
   logic [3:0]          irq_en;            // irq enable mask, bit 0 raster
   vic_pkg::color_t     border_q;          // border colour
   vic_pkg::color_t     background_q;      // background colour
   logic                irq_pend;          // raster irq pending

   logic                bus_rd;            // read access this edge
   logic                bus_wr;            // write access this edge
   logic                irq_ack;           // 1 written to status bit 0
   logic                irq_any;           // enabled pending source
   logic [7:0]          rd_data;           // read mux output

   assign bus_rd  = ~ce & rw;
   assign bus_wr  = ~ce & ~rw;
   assign irq_ack = bus_wr && (adi == vic_pkg::reg_irq_status) && dbi[0];
   assign irq_any = irq_pend & irq_en[0];   // only the raster source exists here

   // settings seen by the video logic
   assign cfg.border     = border_q;
   assign cfg.background = background_q;
   assign cfg.den        = ctrl1.f.den;
   assign cfg.raster_cmp = {ctrl1.f.rst8, raster_lo};   // 9 bit compare line

   // read mux, raster values are taken at the access edge
   always_comb
   begin
      case (adi)
         vic_pkg::reg_ctrl1:
            rd_data = {cfg.raster_line[8], ctrl1.raw[6:0]};   // bit 7 shows beam line
         vic_pkg::reg_raster:
            rd_data = cfg.raster_line[7:0];
         vic_pkg::reg_irq_status:
            rd_data = {irq_any, 6'b000000, irq_pend};
         vic_pkg::reg_irq_enable:
            rd_data = {4'hF, irq_en};                  // upper nibble unused
         vic_pkg::reg_border:
            rd_data = {4'hF, border_q};
         vic_pkg::reg_background:
            rd_data = {4'hF, background_q};
         default:
            rd_data = 8'hFF;                           // unmapped reads float high
      endcase
   end

   // register storage, irq state and bus drive enable
   always_ff @(posedge clk_col16x_ntsc)
   begin
      if (reset)
      begin
         ctrl1.raw    <= 8'h00;
         raster_lo    <= 8'h00;
         irq_en       <= 4'h0;
         border_q     <= 4'h0;
         background_q <= 4'h0;
         irq_pend     <= 1'b0;
         vic_write_db <= 1'b0;
         irq          <= 1'b1;                 // released
      end
      else
      begin
         vic_write_db <= bus_rd;               // one clock after the access
         irq          <= ~irq_any;             // follows pending by one clock

         if (bus_wr)
         begin
            case (adi)
               vic_pkg::reg_ctrl1:      ctrl1.raw    <= dbi;
               vic_pkg::reg_raster:     raster_lo    <= dbi;
               vic_pkg::reg_irq_enable: irq_en       <= dbi[3:0];
               vic_pkg::reg_border:     border_q     <= dbi[3:0];
               vic_pkg::reg_background: background_q <= dbi[3:0];
               default:                 ;       // status handled below, rest ignored
            endcase
         end

         // a new hit wins over an ack in the same clock
         if (cfg.raster_hit)
         begin
            irq_pend <= 1'b1;
         end
         else if (irq_ack)
         begin
            irq_pend <= 1'b0;
         end
      end
   end

   // read data, only meaningful while vic_write_db is high
   always_ff @(posedge clk_col16x_ntsc)
   begin
      if (bus_rd)
      begin
         dbo <= rd_data;
      end
   end

endmodule

`default_nettype wire

// File: verilog/vic_top.sv
`default_nettype none

module vic_top (
   input  wire        clk_col16x_ntsc,
   input  wire        reset,
   input  wire        ce,              // chip enable, low active
   input  wire        rw,              // high reads
   input  wire [5:0]  adi,             // register address
   input  wire [7:0]  dbi,             // cpu write data
   output wire [7:0]  dbo,             // cpu read data
   output wire        vic_write_db,    // data bus drive enable
   output wire        irq,             // low active
   output wire        hsync,
   output wire        vsync,
   output wire [5:0]  luma,
   output wire [5:0]  chroma
);

   vic_pkg::pix_t  pix_x;                  // beam pixel to pixel stage
   vic_pkg::line_t line;                   // beam line to pixel stage

   vic_cfg_if cfg_i ();                    // settings and raster status

   vic_registers vic_registers_i (
      .clk_col16x_ntsc (clk_col16x_ntsc),
      .reset           (reset),
      .ce              (ce),
      .rw              (rw),
      .adi             (adi),
      .dbi             (dbi),
      .dbo             (dbo),
      .vic_write_db    (vic_write_db),
      .irq             (irq),
      .cfg             (cfg_i.regs)
   );

   vic_raster vic_raster_i (
      .clk_col16x_ntsc (clk_col16x_ntsc),
      .reset           (reset),
      .cfg             (cfg_i.video),
      .pix_x           (pix_x),
      .line            (line)
   );

   vic_pixel vic_pixel_i (
      .clk_col16x_ntsc (clk_col16x_ntsc),
      .reset           (reset),
      .pix_x           (pix_x),
      .line            (line),
      .cfg             (cfg_i.video),
      .hsync           (hsync),
      .vsync           (vsync),
      .luma            (luma),
      .chroma          (chroma)
   );

endmodule

`default_nettype wire
